// File: dv/periph_top_tb.sv
`timescale 1ns/1ps

module periph_top_tb import periph_pkg::*; ();

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int ACK_LIMIT       = 8;
    // Any page other than the GPIO one is unmapped
    localparam logic [DBUS_PAGE_W-1:0] OTHER_PAGE = GPIO_BASE + 24'd1;

    logic                  clk;
    logic                  rst_n;
    logic                  dbus_req;
    logic                  dbus_w_en;
    logic [DBUS_AW-1:0]    dbus_addr;
    logic [DBUS_DW-1:0]    dbus_w_data;
    logic                  dbus_ack;
    logic                  dbus_err;
    logic [DBUS_DW-1:0]    dbus_r_data;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic [GPIO_WIDTH-1:0] gpio_oe;
    logic                  gpio_irq;

    // Expected register contents
    logic [7:0]  exp_data;
    logic [7:0]  exp_dir;
    logic [7:0]  exp_ie;
    logic [7:0]  exp_lvl;
    logic [15:0] lfsr_state;
    string       cur_test;
    int          mismatch_count;
    int          fail_count;

    periph_top u_periph_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .dbus_req_i    (dbus_req),
        .dbus_w_en_i   (dbus_w_en),
        .dbus_addr_i   (dbus_addr),
        .dbus_w_data_i (dbus_w_data),
        .dbus_ack_o    (dbus_ack),
        .dbus_err_o    (dbus_err),
        .dbus_r_data_o (dbus_r_data),
        .gpio_in_i     (gpio_in),
        .gpio_out_o    (gpio_out),
        .gpio_oe_o     (gpio_oe),
        .gpio_irq_o    (gpio_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog sized for every test running its full cycle budget
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Taps for x^16 + x^14 + x^13 + x^11 + 1 with the new bit entering at the bottom
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic next_random_byte(output logic [7:0] v);
        v = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch in %s (%s): expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
        mismatch_count++;
    endtask

    // One bus access that starts and ends on a falling edge
    task automatic transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waited;
        waited = 0;
        rdata = '0;
        err = 1'b0;
        dbus_req = 1'b1;
        dbus_w_en = wr;
        dbus_addr = addr;
        dbus_w_data = wdata;
        @(negedge clk);
        while (dbus_ack !== 1'b1 && waited < ACK_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (dbus_ack === 1'b1) begin
            rdata = dbus_r_data;
            err = dbus_err;
        end else begin
            $display("no ack from bus within %0d cycles for access to 0x%08h", ACK_LIMIT, addr);
            fail_count++;
        end
        // Master keeps req low for a cycle between accesses
        dbus_req = 1'b0;
        dbus_w_en = 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] ignored;
        transfer(1'b1, addr, data, ignored, err);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
        transfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic write_reg(input type_gpio_regs_e r, input logic [7:0] v);
        logic err;
        bus_write({GPIO_BASE, r}, {24'd0, v}, err);
        if (err !== 1'b0) report_mismatch("write err", 32'd0, {31'd0, err});
    endtask

    task automatic expect_reg(input type_gpio_regs_e r, input logic [7:0] exp);
        logic [31:0] rd;
        logic        err;
        bus_read({GPIO_BASE, r}, rd, err);
        if (err !== 1'b0) report_mismatch("read err", 32'd0, {31'd0, err});
        if (rd !== {24'd0, exp}) report_mismatch(r.name(), {24'd0, exp}, rd);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic reset_values();
        cur_test = "reset_values";
        if (gpio_oe !== 8'd0) report_mismatch("gpio_oe", 32'd0, {24'd0, gpio_oe});
        if (gpio_out !== 8'd0) report_mismatch("gpio_out", 32'd0, {24'd0, gpio_out});
        if (gpio_irq !== 1'b0) report_mismatch("gpio_irq", 32'd0, {31'd0, gpio_irq});
        expect_reg(GPIO_DATA_R, 8'd0);
        expect_reg(GPIO_DIR_R, 8'd0);
        expect_reg(GPIO_IE_R, 8'd0);
        expect_reg(GPIO_INT_LVL_R, 8'd0);
        // Low pins sit at level 0 and so every bit is pending one cycle after reset
        expect_reg(GPIO_IP_R, ~(exp_data ^ exp_lvl));
    endtask

    task automatic register_readback();
        logic [7:0] v;
        cur_test = "register_readback";
        next_random_byte(exp_dir);
        write_reg(GPIO_DIR_R, exp_dir);
        expect_reg(GPIO_DIR_R, exp_dir);
        next_random_byte(exp_ie);
        write_reg(GPIO_IE_R, exp_ie);
        expect_reg(GPIO_IE_R, exp_ie);
        next_random_byte(exp_lvl);
        write_reg(GPIO_INT_LVL_R, exp_lvl);
        expect_reg(GPIO_INT_LVL_R, exp_lvl);
        // IP is read only
        next_random_byte(v);
        write_reg(GPIO_IP_R, v);
        expect_reg(GPIO_IP_R, ~(exp_data ^ exp_lvl));
    endtask

    task automatic output_drive();
        logic [7:0] w;
        cur_test = "output_drive";
        next_random_byte(exp_dir);
        write_reg(GPIO_DIR_R, exp_dir);
        next_random_byte(w);
        write_reg(GPIO_DATA_R, w);
        exp_data = (exp_dir & w) | (~exp_dir & gpio_in);
        if (gpio_oe !== exp_dir) report_mismatch("gpio_oe", {24'd0, exp_dir}, {24'd0, gpio_oe});
        if ((gpio_out & exp_dir) !== (w & exp_dir)) begin
            report_mismatch("gpio_out", {24'd0, w & exp_dir}, {24'd0, gpio_out & exp_dir});
        end
        expect_reg(GPIO_DATA_R, exp_data);
    endtask

    task automatic input_sampling();
        logic [7:0] p;
        cur_test = "input_sampling";
        exp_dir = 8'h0F;
        write_reg(GPIO_DIR_R, exp_dir);
        next_random_byte(p);
        gpio_in = p;
        // Two synchronizer stages then the data register
        repeat (3) @(negedge clk);
        exp_data = (exp_dir & exp_data) | (~exp_dir & p);
        expect_reg(GPIO_DATA_R, exp_data);
    endtask

    task automatic interrupt_levels();
        logic [7:0] exp_ip;
        cur_test = "interrupt_levels";
        next_random_byte(exp_lvl);
        next_random_byte(exp_ie);
        // Pin 4 is an input and starts pending and enabled
        exp_lvl[4] = exp_data[4];
        exp_ie[4] = 1'b1;
        write_reg(GPIO_INT_LVL_R, exp_lvl);
        write_reg(GPIO_IE_R, exp_ie);
        @(negedge clk);
        exp_ip = ~(exp_data ^ exp_lvl);
        expect_reg(GPIO_IP_R, exp_ip);
        if (gpio_irq !== |(exp_ie & exp_ip)) begin
            report_mismatch("gpio_irq", {31'd0, |(exp_ie & exp_ip)}, {31'd0, gpio_irq});
        end
        // Only pin 4 enabled so the request follows its pending bit alone
        exp_ie = 8'h10;
        write_reg(GPIO_IE_R, exp_ie);
        if (gpio_irq !== |(exp_ie & exp_ip)) begin
            report_mismatch("gpio_irq", {31'd0, |(exp_ie & exp_ip)}, {31'd0, gpio_irq});
        end
        // Move pin 4 off its level
        gpio_in[4] = ~exp_lvl[4];
        // Pending bit still holds after 3 cycles
        repeat (3) @(negedge clk);
        if (gpio_irq !== |(exp_ie & exp_ip)) begin
            report_mismatch("gpio_irq early", {31'd0, |(exp_ie & exp_ip)}, {31'd0, gpio_irq});
        end
        // Pending bit clears on the fourth cycle
        @(negedge clk);
        exp_data = (exp_dir & exp_data) | (~exp_dir & gpio_in);
        exp_ip = ~(exp_data ^ exp_lvl);
        if (gpio_irq !== |(exp_ie & exp_ip)) begin
            report_mismatch("gpio_irq", {31'd0, |(exp_ie & exp_ip)}, {31'd0, gpio_irq});
        end
        expect_reg(GPIO_IP_R, exp_ip);
    endtask

    task automatic unmapped_access();
        logic [31:0] rd;
        logic        err;
        cur_test = "unmapped_access";
        bus_read({OTHER_PAGE, GPIO_DIR_R}, rd, err);
        if (err !== 1'b1) report_mismatch("read err", 32'd1, {31'd0, err});
        if (rd !== 32'd0) report_mismatch("read data", 32'd0, rd);
        bus_write({OTHER_PAGE, GPIO_DIR_R}, {24'd0, ~exp_dir}, err);
        if (err !== 1'b1) report_mismatch("write err", 32'd1, {31'd0, err});
        // Nothing in the GPIO block may move
        expect_reg(GPIO_DIR_R, exp_dir);
        expect_reg(GPIO_DATA_R, exp_data);
        expect_reg(GPIO_INT_LVL_R, exp_lvl);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        rst_n = 1'b0;
        dbus_req = 1'b0;
        dbus_w_en = 1'b0;
        dbus_addr = '0;
        dbus_w_data = '0;
        gpio_in = '0;
        exp_data = '0;
        exp_dir = '0;
        exp_ie = '0;
        exp_lvl = '0;
        lfsr_state = 16'd79;
        mismatch_count = 0;
        fail_count = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        reset_values();
        register_readback();
        output_drive();
        input_sampling();
        interrupt_levels();
        unmapped_access();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: periph_top.f
rtl/periph_pkg.sv
rtl/gpio_pin_sync.sv
rtl/gpio.sv
rtl/dbus_decoder.sv
rtl/periph_top.sv
dv/periph_top_tb.sv

// File: rtl/dbus_decoder.sv
`timescale 1ns/1ps

module dbus_decoder import periph_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // Master side
    input  logic                   req_i,
    input  logic [DBUS_PAGE_W-1:0] addr_page_i,
    // GPIO response
    input  logic                   gpio_ack_i,
    input  logic [DBUS_DW-1:0]     gpio_r_data_i,
    // Slave select
    output logic                   gpio_sel_o,
    // Merged response to the master
    output logic                   ack_o,
    output logic                   err_o,
    output logic [DBUS_DW-1:0]     r_data_o
);

    // Page hit for the GPIO block
    logic gpio_hit;
    // Request to a page no slave owns
    logic unmapped;
    // Registered error ack
    logic err_ack_q;

    // ----------------------------------------
    // Page decode
    // ----------------------------------------

    // Select depends on the page only, the slave qualifies with req
    assign gpio_hit   = (addr_page_i == GPIO_BASE);
    assign gpio_sel_o = gpio_hit;

    // Repeat of the request in the ack cycle is not answered again
    assign unmapped = req_i & ~gpio_hit & ~err_ack_q;

    // ----------------------------------------
    // Error response
    // ----------------------------------------

    // One cycle after req, same timing as a real slave
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= unmapped;
        end
    end

    // ----------------------------------------
    // Response merge
    // ----------------------------------------

    // At most one of the two acks is high in a cycle
    assign ack_o = gpio_ack_i | err_ack_q;
    assign err_o = err_ack_q;

    // Error reads return zero
    always_comb begin
        if (err_ack_q) begin
            r_data_o = '0;
        end else begin
            r_data_o = gpio_r_data_i;
        end
    end

endmodule

// File: rtl/gpio.sv
`timescale 1ns/1ps

module gpio import periph_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // Bus side
    input  logic                  gpio_sel_i,
    input  logic                  req_i,
    input  logic                  w_en_i,
    input  logic [DBUS_OFS_W-1:0] reg_addr_i,
    input  logic [DBUS_DW-1:0]    w_data_i,
    output logic                  ack_o,
    output logic [DBUS_DW-1:0]    r_data_o,
    // Pin side
    input  logic [GPIO_WIDTH-1:0] pin_i,
    output logic [GPIO_WIDTH-1:0] pin_out_o,
    output logic [GPIO_WIDTH-1:0] pin_oe_o,
    output logic                  irq_o
);

    // Register state
    logic [GPIO_WIDTH-1:0] data_q;
    logic [GPIO_WIDTH-1:0] dir_q;
    logic [GPIO_WIDTH-1:0] ip_q;
    logic [GPIO_WIDTH-1:0] ie_q;
    logic [GPIO_WIDTH-1:0] int_lvl_q;

    // Next data value, output bits from the bus and input bits from the pins
    logic [GPIO_WIDTH-1:0] data_d;
    logic [GPIO_WIDTH-1:0] data_wr;

    // Bus response registers
    logic                  ack_q;
    logic [DBUS_DW-1:0]    r_data_q;

    // Decoded access
    type_gpio_regs_e       reg_addr;
    logic                  acc_en;
    logic                  wr_en;
    logic                  we_data;
    logic                  we_dir;
    logic                  we_ie;
    logic                  we_int_lvl;
    logic [DBUS_DW-1:0]    rd_mux;

    // ----------------------------------------
    // Access decode
    // ----------------------------------------

    assign reg_addr = type_gpio_regs_e'(reg_addr_i);

    // A request in the cycle of our own ack is the previous access, drop it
    assign acc_en = gpio_sel_i & req_i & ~ack_q;
    assign wr_en  = acc_en & w_en_i;

    always_comb begin
        we_data    = 1'b0;
        we_dir     = 1'b0;
        we_ie      = 1'b0;
        we_int_lvl = 1'b0;
        if (wr_en) begin
            case (reg_addr)
                GPIO_DATA_R:    we_data    = 1'b1;
                GPIO_DIR_R:     we_dir     = 1'b1;
                GPIO_IE_R:      we_ie      = 1'b1;
                GPIO_INT_LVL_R: we_int_lvl = 1'b1;
                // IP is read only, unknown offsets are ignored
                default: ;
            endcase
        end
    end

    // Read mux, zero extended to the bus width
    always_comb begin
        case (reg_addr)
            GPIO_DATA_R:    rd_mux = {{(DBUS_DW-GPIO_WIDTH){1'b0}}, data_q};
            GPIO_DIR_R:     rd_mux = {{(DBUS_DW-GPIO_WIDTH){1'b0}}, dir_q};
            GPIO_IP_R:      rd_mux = {{(DBUS_DW-GPIO_WIDTH){1'b0}}, ip_q};
            GPIO_IE_R:      rd_mux = {{(DBUS_DW-GPIO_WIDTH){1'b0}}, ie_q};
            GPIO_INT_LVL_R: rd_mux = {{(DBUS_DW-GPIO_WIDTH){1'b0}}, int_lvl_q};
            default:        rd_mux = '0;
        endcase
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------

    // Output bits keep their value unless DATA is written
    assign data_wr = we_data ? w_data_i[GPIO_WIDTH-1:0] : data_q;
    // Input bits follow the synchronized pins every cycle
    assign data_d  = (dir_q & data_wr) | (~dir_q & pin_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q    <= '0;
            dir_q     <= '0;
            ip_q      <= '0;
            ie_q      <= '0;
            int_lvl_q <= '0;
        end else begin
            data_q <= data_d;
            if (we_dir) begin
                dir_q <= w_data_i[GPIO_WIDTH-1:0];
            end
            if (we_ie) begin
                ie_q <= w_data_i[GPIO_WIDTH-1:0];
            end
            if (we_int_lvl) begin
                int_lvl_q <= w_data_i[GPIO_WIDTH-1:0];
            end
            // Pending where the pin sits at its interrupt level
            ip_q <= ~(data_q ^ int_lvl_q);
        end
    end

    // ----------------------------------------
    // Bus response
    // ----------------------------------------

    // Ack is a one cycle pulse, the guard on ack_q prevents a second one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= acc_en;
        end
    end

    // Read data only matters in the ack cycle
    always_ff @(posedge clk) begin
        if (acc_en) begin
            r_data_q <= w_en_i ? '0 : rd_mux;
        end
    end

    assign ack_o    = ack_q;
    assign r_data_o = r_data_q;

    // ----------------------------------------
    // Pins and interrupt
    // ----------------------------------------

    // Pad driven from DATA where DIR marks an output
    assign pin_out_o = data_q;
    assign pin_oe_o  = dir_q;

    // Any enabled pending pin raises the request
    assign irq_o = |(ie_q & ip_q);

endmodule

// File: rtl/gpio_pin_sync.sv
`timescale 1ns/1ps

module gpio_pin_sync import periph_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [GPIO_WIDTH-1:0] pin_i,
    output logic [GPIO_WIDTH-1:0] pin_o
);

    // Flop chain, stage 0 samples the raw pins
    logic [GPIO_WIDTH-1:0] sync_q [SYNC_STAGES];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
        end else begin
            // First stage may go metastable, the rest settle it
            sync_q[0] <= pin_i;
            for (int s = 1; s < SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    // Last stage is safe to use in the clk domain
    assign pin_o = sync_q[SYNC_STAGES-1];

endmodule

// File: rtl/periph_pkg.sv
package periph_pkg;

    // ----------------------------------------
    // Data bus geometry
    // ----------------------------------------

    // Address and data width of the data bus
    localparam int DBUS_AW = 32;
    localparam int DBUS_DW = 32;

    // Low address bits select a register inside a peripheral page
    localparam int DBUS_OFS_W = 8;

    // Upper address bits select the peripheral page
    localparam int DBUS_PAGE_W = DBUS_AW - DBUS_OFS_W;

    // ----------------------------------------
    // Address map
    // ----------------------------------------

    // GPIO page, compared against addr[31:8]
    localparam logic [DBUS_PAGE_W-1:0] GPIO_BASE = 24'h000001;

    // ----------------------------------------
    // GPIO block
    // ----------------------------------------

    // Number of pins, one bit per pin in every register
    localparam int GPIO_WIDTH = 8;

    // Flops in the input pin synchronizer
    localparam int SYNC_STAGES = 2;

    // Register offsets inside the GPIO page
    typedef enum logic [DBUS_OFS_W-1:0] {
        // Pin data, outputs written, inputs sampled
        GPIO_DATA_R    = 8'h00,
        // Direction, 1 output and 0 input
        GPIO_DIR_R     = 8'h04,
        // Interrupt pending, read only
        GPIO_IP_R      = 8'h08,
        // Interrupt enable
        GPIO_IE_R      = 8'h0C,
        // Level that raises the pending bit
        GPIO_INT_LVL_R = 8'h10
    } type_gpio_regs_e;

endpackage

// File: rtl/periph_top.sv
`timescale 1ns/1ps

module periph_top import periph_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    // Data bus
    input  logic                  dbus_req_i,
    input  logic                  dbus_w_en_i,
    input  logic [DBUS_AW-1:0]    dbus_addr_i,
    input  logic [DBUS_DW-1:0]    dbus_w_data_i,
    output logic                  dbus_ack_o,
    output logic                  dbus_err_o,
    output logic [DBUS_DW-1:0]    dbus_r_data_o,
    // Pads
    input  logic [GPIO_WIDTH-1:0] gpio_in_i,
    output logic [GPIO_WIDTH-1:0] gpio_out_o,
    output logic [GPIO_WIDTH-1:0] gpio_oe_o,
    output logic                  gpio_irq_o
);

    // Decoder to GPIO
    logic                  gpio_sel;
    logic                  gpio_ack;
    logic [DBUS_DW-1:0]    gpio_r_data;
    // Pins after the synchronizer
    logic [GPIO_WIDTH-1:0] pin_sync;

    // Address split, page to the decoder and offset to the slave
    dbus_decoder u_dbus_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_i         (dbus_req_i),
        .addr_page_i   (dbus_addr_i[DBUS_AW-1:DBUS_OFS_W]),
        .gpio_ack_i    (gpio_ack),
        .gpio_r_data_i (gpio_r_data),
        .gpio_sel_o    (gpio_sel),
        .ack_o         (dbus_ack_o),
        .err_o         (dbus_err_o),
        .r_data_o      (dbus_r_data_o)
    );

    gpio_pin_sync u_gpio_pin_sync (
        .clk   (clk),
        .rst_n (rst_n),
        .pin_i (gpio_in_i),
        .pin_o (pin_sync)
    );

    gpio u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .gpio_sel_i (gpio_sel),
        .req_i      (dbus_req_i),
        .w_en_i     (dbus_w_en_i),
        .reg_addr_i (dbus_addr_i[DBUS_OFS_W-1:0]),
        .w_data_i   (dbus_w_data_i),
        .ack_o      (gpio_ack),
        .r_data_o   (gpio_r_data),
        .pin_i      (pin_sync),
        .pin_out_o  (gpio_out_o),
        .pin_oe_o   (gpio_oe_o),
        .irq_o      (gpio_irq_o)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for a failure
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module periph_top_tb -f periph_top.f \
    --Mdir obj_dir -o periph_top_sim > build.log 2>&1 \
    && ./obj_dir/periph_top_sim > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }

cat "$LOG"
grep -q "TEST FAILED" "$LOG" && { echo "simulation reported failure"; exit 1; }
echo "simulation passed"
